//--- hdl/gpio_pkg.sv
// Constants shared by the GPIO peripheral RTL
// The design only supports these values of width, pin count and clock frequency
package gpio_pkg;

	// Bus and pin widths
	localparam int unsigned ARCH_W   = 32;
	localparam int unsigned IO_COUNT = 8;

	// Debounce threshold uses every data bit except the command bit
	localparam int unsigned THRESH_W = ARCH_W - 1;

	// Clock frequency in Hz, reported to software
	localparam logic [ARCH_W-1:0] CLK_FREQ = 32'd100_000_000;

	// Bus opcodes
	localparam logic [1:0] OP_NOP = 2'd0;
	localparam logic [1:0] OP_WR  = 2'd1;
	localparam logic [1:0] OP_RD  = 2'd2;
	localparam logic [1:0] OP_RW  = 2'd3;

	// Command select for OP_RW lives in the top data bit
	localparam int unsigned CMD_BIT = ARCH_W - 1;

	localparam logic CMD_CONFIG_IO    = 1'b0; // Load mask, reply pin count
	localparam logic CMD_SET_DEBOUNCE = 1'b1; // Load threshold, reply clock frequency

endpackage

//--- hdl/pin_debouncer.sv
// Single pin glitch filter. pin_i must already be synchronous to clk_i
// Output follows a new level after threshold+1 consecutive cycles
`timescale 1ns/100ps

module pin_debouncer import gpio_pkg::*; (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                pin_i,
	input  logic [THRESH_W-1:0] thresh_i,
	output logic                pin_o
);

	logic [THRESH_W-1:0] run_cnt; // Consecutive cycles of disagreement
	logic                differ;
	logic                expired;

	assign differ = pin_i ^ pin_o;

	// Greater-or-equal also recovers when the threshold is lowered mid-count
	assign expired = (run_cnt >= thresh_i);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			run_cnt <= '0;
			pin_o   <= 1'b0;
		end else if (!differ) begin
			run_cnt <= '0; // Input agrees again, restart the run
		end else if (expired) begin
			pin_o   <= pin_i;
			run_cnt <= '0;
		end else begin
			run_cnt <= run_cnt + 1'b1;
		end
	end

endmodule

//--- hdl/pin_change_irq.sv
// Change detector on the unmasked filtered pins
// The request is sticky until a falling edge on intrdy_i
`timescale 1ns/100ps

module pin_change_irq import gpio_pkg::*; (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic [IO_COUNT-1:0] filtered_i,
	input  logic [IO_COUNT-1:0] mask_i,
	input  logic                intrdy_i,
	output logic [IO_COUNT-1:0] ival_o,
	output logic                intrqst_o
);

	logic [IO_COUNT-1:0] ival_q;   // Unmasked value from the previous cycle
	logic [IO_COUNT-1:0] changed;
	logic [IO_COUNT-1:0] change_q; // Sticky per-pin change flags
	logic                intrdy_q;
	logic                ack_fall;

	// Masked pins read as zero and never toggle the detector
	assign ival_o = filtered_i & ~mask_i;

	assign changed  = ival_o ^ ival_q;
	assign ack_fall = intrdy_q & ~intrdy_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ival_q   <= '0;
			intrdy_q <= 1'b0;
		end else begin
			ival_q   <= ival_o;
			intrdy_q <= intrdy_i;
		end
	end

	// Acknowledge wins over a change arriving in the same cycle
	always_ff @(posedge clk_i) begin
		if (rst_i)
			change_q <= '0;
		else if (ack_fall)
			change_q <= '0;
		else
			change_q <= change_q | changed;
	end

	assign intrqst_o = |change_q;

endmodule

//--- hdl/gpio_regs.sv
// Bus register block. Every operation completes in the cycle it is presented
// Reply data is registered and holds until the next OP_RD or OP_RW
`timescale 1ns/100ps

module gpio_regs import gpio_pkg::*; (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic [1:0]          op_i,
	input  logic [ARCH_W-1:0]   data_i,
	output logic [ARCH_W-1:0]   data_o,
	input  logic [IO_COUNT-1:0] ival_i,
	output logic [IO_COUNT-1:0] pins_o,
	output logic [IO_COUNT-1:0] mask_o,
	output logic [THRESH_W-1:0] thresh_o
);

	logic              cmd;
	logic              wr_en;
	logic              rd_en;
	logic              cfg_en;
	logic              dbnc_en;
	logic              reply_en;
	logic [ARCH_W-1:0] reply;

	assign cmd = data_i[CMD_BIT];

	// Opcode and command decode
	always_comb begin
		wr_en   = 1'b0;
		rd_en   = 1'b0;
		cfg_en  = 1'b0;
		dbnc_en = 1'b0;
		case (op_i)
			OP_NOP: ; // Bus idle
			OP_WR:  wr_en = 1'b1;
			OP_RD:  rd_en = 1'b1;
			OP_RW: begin
				cfg_en  = (cmd == CMD_CONFIG_IO);
				dbnc_en = (cmd == CMD_SET_DEBOUNCE);
			end
			default: ;
		endcase
	end

	assign reply_en = rd_en | cfg_en | dbnc_en;

	// Reply selection
	always_comb begin
		reply = '0;
		if (rd_en)
			reply = {{(ARCH_W-IO_COUNT){1'b0}}, ival_i};
		else if (cfg_en)
			reply = ARCH_W'(IO_COUNT);
		else if (dbnc_en)
			reply = CLK_FREQ;
	end

	// Output pin levels, upper data bits are ignored
	always_ff @(posedge clk_i) begin
		if (rst_i)
			pins_o <= '0;
		else if (wr_en)
			pins_o <= data_i[IO_COUNT-1:0];
	end

	// Per-pin mask, a set bit hides the pin from reads and interrupts
	always_ff @(posedge clk_i) begin
		if (rst_i)
			mask_o <= '0;
		else if (cfg_en)
			mask_o <= data_i[IO_COUNT-1:0];
	end

	// Shared debounce threshold
	always_ff @(posedge clk_i) begin
		if (rst_i)
			thresh_o <= '0;
		else if (dbnc_en)
			thresh_o <= data_i[THRESH_W-1:0];
	end

	always_ff @(posedge clk_i) begin
		if (rst_i)
			data_o <= '0;
		else if (reply_en)
			data_o <= reply; // Held while the bus writes or idles
	end

endmodule

//--- hdl/gpio_top.sv
// GPIO peripheral top. Pins are debounced, then change detected, then read over the bus
// pins_i must be synchronous to clk_i. Interrupt latency is threshold+2 edges
`timescale 1ns/100ps

module gpio_top import gpio_pkg::*; (
	input  logic                clk_i,
	input  logic                rst_i,

	// Processor bus
	input  logic [1:0]          op_i,
	input  logic [ARCH_W-1:0]   data_i,
	output logic [ARCH_W-1:0]   data_o,

	// Pads
	input  logic [IO_COUNT-1:0] pins_i,
	output logic [IO_COUNT-1:0] pins_o,
	output logic [IO_COUNT-1:0] mask_o,

	// Interrupt controller
	output logic                intrqst_o,
	input  logic                intrdy_i
);

	logic [THRESH_W-1:0] thresh;
	logic [IO_COUNT-1:0] filtered;
	logic [IO_COUNT-1:0] ival;

	// One filter per pin, all sharing the same threshold
	for (genvar i = 0; i < IO_COUNT; i++) begin : g_dbnc
		pin_debouncer pin_debouncer_inst (
			.clk_i    (clk_i),
			.rst_i    (rst_i),
			.pin_i    (pins_i[i]),
			.thresh_i (thresh),
			.pin_o    (filtered[i])
		);
	end

	pin_change_irq pin_change_irq_inst (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.filtered_i (filtered),
		.mask_i     (mask_o),
		.intrdy_i   (intrdy_i),
		.ival_o     (ival),
		.intrqst_o  (intrqst_o)
	);

	gpio_regs gpio_regs_inst (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.op_i     (op_i),
		.data_i   (data_i),
		.data_o   (data_o),
		.ival_i   (ival),
		.pins_o   (pins_o),
		.mask_o   (mask_o),
		.thresh_o (thresh)
	);

endmodule

//--- dv/gpio_clkgen.sv
// Free running 10 ns clock, reset held high for the first 4 rising edges
`timescale 1ns/100ps

module gpio_clkgen (
	output logic clk_o,
	output logic rst_o
);

	localparam int HALF_PERIOD = 5;
	localparam int RST_CYCLES  = 4;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		#1 rst_o = 1'b0; // Released just after the edge
	end

endmodule

//--- dv/gpio_chk.sv
// Assertions bound into every pin_change_irq instance
// Covers the reset, acknowledge and request-rise behavior
`timescale 1ns/100ps

module gpio_chk import gpio_pkg::*; (
	input logic                clk_i,
	input logic                rst_i,
	input logic [IO_COUNT-1:0] ival_i,
	input logic                intrdy_i,
	input logic                intrqst_i
);

	int unsigned fail_cnt = 0; // Number of failed assertion checks

	a_rst_clear: assert property (@(posedge clk_i) rst_i |=> !intrqst_i)
		else begin
			$error("intrqst_o high in the cycle after reset");
			fail_cnt++;
		end

	// Sampled falling edge of intrdy_i clears the latch at that edge
	a_ack_clear: assert property (@(posedge clk_i) disable iff (rst_i)
		(!$past(rst_i) && $fell(intrdy_i)) |=> !intrqst_i)
		else begin
			$error("intrqst_o not cleared by the acknowledge falling edge");
			fail_cnt++;
		end

	a_rise_cause: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(intrqst_i) |-> ($past(ival_i, 1) != $past(ival_i, 2)))
		else begin
			$error("intrqst_o rose without a change of ival");
			fail_cnt++;
		end

endmodule

bind pin_change_irq gpio_chk gpio_chk_inst (
	.clk_i     (clk_i),
	.rst_i     (rst_i),
	.ival_i    (ival_o),
	.intrdy_i  (intrdy_i),
	.intrqst_i (intrqst_o)
);

//--- dv/gpio_tb.sv
// Directed testbench for gpio_top, inputs change 1 ns after the rising edge
// Expects the package values of 8 pins and a 32-bit bus
`timescale 1ns/100ps

module gpio_tb import gpio_pkg::*; ();

	localparam int DRIVE_DELAY = 1;
	localparam int TIMEOUT_CYC = 3000;
	localparam int DBNC_T      = 4; // Debounce threshold for the pin tests
	localparam int GLITCH_LEN  = DBNC_T - 1;
	localparam int N_WRITES    = 6;
	localparam logic [31:0] EXP_PINS = 32'd8;
	localparam logic [31:0] EXP_FREQ = 32'd100_000_000;

	logic                clk;
	logic                rst;
	logic [1:0]          op;
	logic [ARCH_W-1:0]   data_in;
	logic [ARCH_W-1:0]   data_out;
	logic [IO_COUNT-1:0] pins_in;
	logic [IO_COUNT-1:0] pins_out;
	logic [IO_COUNT-1:0] mask_out;
	logic                intrqst;
	logic                intrdy;

	integer      seed      = 83921;
	int unsigned cycles    = 0;
	int unsigned errors    = 0;
	int unsigned tests_ok  = 0;
	int unsigned tests_bad = 0;

	gpio_clkgen clkgen_inst (
		.clk_o (clk),
		.rst_o (rst)
	);

	gpio_top gpio_top_inst (
		.clk_i     (clk),
		.rst_i     (rst),
		.op_i      (op),
		.data_i    (data_in),
		.data_o    (data_out),
		.pins_i    (pins_in),
		.pins_o    (pins_out),
		.mask_o    (mask_out),
		.intrqst_o (intrqst),
		.intrdy_i  (intrdy)
	);

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("Run stopped, no result after %0d cycles", TIMEOUT_CYC);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic step();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("FAIL %s expected %h actual %h", name, exp, act);
		errors++;
	endtask

	task automatic bus_op(input logic [1:0] code, input logic [31:0] word);
		op      = code;
		data_in = word;
		step();
		op      = OP_NOP;
	endtask

	task automatic ack_irq();
		intrdy = 1'b1;
		step();
		intrdy = 1'b0;
		step(); // Falling edge sampled here
	endtask

	task automatic wait_irq(output bit seen);
		int n;
		n = 0;
		while (!intrqst && n < DBNC_T + 3) begin
			step();
			n++;
		end
		seen = intrqst;
	endtask

	task automatic end_test(input string name, input int unsigned errs_before);
		if (errors == errs_before) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic reset_values();
		int unsigned e0;
		e0 = errors;
		if (pins_out !== '0)
			mismatch("pins_o", 32'h0, 32'(pins_out));
		if (mask_out !== '0)
			mismatch("mask_o", 32'h0, 32'(mask_out));
		if (data_out !== '0)
			mismatch("data_o", 32'h0, data_out);
		if (intrqst !== 1'b0)
			mismatch("intrqst_o", 32'h0, 32'(intrqst));
		end_test("reset state", e0);
	endtask

	task automatic output_writes();
		int unsigned         e0;
		logic [31:0]         w;
		logic [IO_COUNT-1:0] m;
		e0 = errors;
		m  = mask_out;
		for (int i = 0; i < N_WRITES; i++) begin
			w = $random(seed);
			bus_op(OP_WR, w);
			if (pins_out !== w[7:0])
				mismatch("pins_o", 32'(w[7:0]), 32'(pins_out));
			if (mask_out !== m)
				mismatch("mask_o", 32'(m), 32'(mask_out));
		end
		end_test("output write", e0);
	endtask

	task automatic command_replies();
		int unsigned e0;
		logic [7:0]  m;
		e0 = errors;
		m  = 8'($random(seed));
		bus_op(OP_RW, {CMD_CONFIG_IO, 23'h0, m});
		if (mask_out !== m)
			mismatch("mask_o", 32'(m), 32'(mask_out));
		if (data_out !== EXP_PINS)
			mismatch("data_o", EXP_PINS, data_out);
		bus_op(OP_WR, 32'h0000_005a); // Reply must hold across a write
		if (data_out !== EXP_PINS)
			mismatch("data_o", EXP_PINS, data_out);
		bus_op(OP_RW, {CMD_SET_DEBOUNCE, 31'(DBNC_T)});
		if (data_out !== EXP_FREQ)
			mismatch("data_o", EXP_FREQ, data_out);
		bus_op(OP_RW, {CMD_CONFIG_IO, 31'h0});
		if (mask_out !== '0)
			mismatch("mask_o", 32'h0, 32'(mask_out));
		end_test("commands", e0);
	endtask

	task automatic debounce_reads();
		int unsigned e0;
		logic [7:0]  cur;
		logic [7:0]  v;
		logic [7:0]  g;
		int          first;
		e0    = errors;
		cur   = pins_in;
		first = 0;
		bus_op(OP_RD, 32'h0);
		if (data_out !== {24'h0, cur})
			mismatch("data_o", {24'h0, cur}, data_out);
		do
			v = 8'($random(seed));
		while (v == cur);
		op      = OP_RD;
		pins_in = v;
		for (int k = 1; k <= DBNC_T + 3; k++) begin
			step();
			if (first == 0 && data_out[7:0] == v)
				first = k;
		end
		if (first == 0) begin
			$display("Debounced level %h did not appear within %0d cycles", v, DBNC_T + 3);
			errors++;
		end else if (first < DBNC_T + 1) begin
			$display("Debounced level %h appeared after only %0d cycles", v, first);
			errors++;
		end
		if (data_out !== {24'h0, v})
			mismatch("data_o", {24'h0, v}, data_out);
		do
			g = 8'($random(seed));
		while (g == '0);
		pins_in = v ^ g; // Glitch shorter than the threshold
		for (int k = 0; k < GLITCH_LEN + DBNC_T + 3; k++) begin
			step();
			if (k == GLITCH_LEN - 1)
				pins_in = v;
			if (data_out !== {24'h0, v})
				mismatch("data_o", {24'h0, v}, data_out);
		end
		op = OP_NOP;
		end_test("debounce and read", e0);
	endtask

	task automatic masked_pins();
		int unsigned e0;
		logic [7:0]  m;
		e0 = errors;
		do
			m = 8'($random(seed));
		while (m == '0 || m == '1);
		bus_op(OP_RW, {CMD_CONFIG_IO, 23'h0, m});
		repeat (3) step(); // Hiding high pins is itself a change
		ack_irq();
		step();
		if (intrqst !== 1'b0)
			mismatch("intrqst_o", 32'h0, 32'(intrqst));
		pins_in = pins_in ^ m;
		op      = OP_RD;
		for (int k = 0; k < DBNC_T + 4; k++) begin
			step();
			if (intrqst !== 1'b0)
				mismatch("intrqst_o", 32'h0, 32'(intrqst));
			if ((data_out[7:0] & m) !== '0)
				mismatch("data_o", 32'h0, 32'(data_out[7:0] & m));
		end
		op = OP_NOP;
		if (data_out !== {24'h0, pins_in & ~m})
			mismatch("data_o", {24'h0, pins_in & ~m}, data_out);
		bus_op(OP_RW, {CMD_CONFIG_IO, 31'h0});
		end_test("masking", e0);
	endtask

	task automatic irq_handshake();
		int unsigned e0;
		logic [7:0]  g;
		bit          seen;
		e0 = errors;
		repeat (3) step();
		ack_irq();
		step();
		if (intrqst !== 1'b0)
			mismatch("intrqst_o", 32'h0, 32'(intrqst));
		for (int pass = 0; pass < 2; pass++) begin
			do
				g = 8'($random(seed));
			while (g == '0);
			pins_in = pins_in ^ g;
			wait_irq(seen);
			if (!seen) begin
				$display("intrqst_o did not rise within %0d cycles of a pin change", DBNC_T + 3);
				errors++;
			end
			repeat (DBNC_T + 2) begin
				step();
				if (intrqst !== 1'b1)
					mismatch("intrqst_o", 32'h1, 32'(intrqst));
			end
			intrdy = 1'b1;
			step();
			if (intrqst !== 1'b1)
				mismatch("intrqst_o", 32'h1, 32'(intrqst));
			intrdy = 1'b0;
			step();
			if (intrqst !== 1'b0)
				mismatch("intrqst_o", 32'h0, 32'(intrqst));
			step();
			if (intrqst !== 1'b0)
				mismatch("intrqst_o", 32'h0, 32'(intrqst));
		end
		end_test("interrupt", e0);
	endtask

	initial begin
		op      = OP_NOP;
		data_in = '0;
		pins_in = '0;
		intrdy  = 1'b0;
		@(negedge rst);
		reset_values();
		output_writes();
		command_replies();
		debounce_reads();
		masked_pins();
		irq_handshake();
		if (gpio_top_inst.pin_change_irq_inst.gpio_chk_inst.fail_cnt != 0) begin
			$display("Bound assertions failed %0d times",
				gpio_top_inst.pin_change_irq_inst.gpio_chk_inst.fail_cnt);
			errors++;
		end
		$display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- verilog.f
hdl/gpio_pkg.sv
hdl/pin_debouncer.sv
hdl/pin_change_irq.sv
hdl/gpio_regs.sv
hdl/gpio_top.sv
dv/gpio_clkgen.sv
dv/gpio_chk.sv
dv/gpio_tb.sv
